//--- build.sh
#!/bin/sh
# Compiles the testbench with Verilator, runs it and scans the log for the fail message
LOG=sim.log
verilator --binary --timing --assert -f project.f --top-module fp_pipeline_tb \
	-o fp_pipeline_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/fp_pipeline_sim > "$LOG" 2>&1 || echo "Simulator returned an error status" >> "$LOG"
cat "$LOG"
grep -qF "*** TEST FAILED ***" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" "$LOG" && echo "Simulation passed" \
	|| { echo "Simulation ended without a result"; exit 1; }

//--- project.f
rtl/fp_pipe_pkg.sv
rtl/fp_unpack_compare_stage.sv
rtl/fp_align_multiply_stage.sv
rtl/fp_add_normalize_stage.sv
rtl/fp_round_pack_stage.sv
rtl/fp_vector_pipeline.sv
+incdir+verification
verification/fp_pipeline_tb.sv

//--- rtl/fp_add_normalize_stage.sv
/*
 * Stage 3. Adds or subtracts the aligned significands and normalizes both the
 * sum and the product. An exact zero leaves with exponent 0.
 */
`timescale 1ns/1ps

module fp_add_normalize_stage import fp_pipe_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic s2_valid,
	input  fp_op_t s2_op,
	input  logic [THREAD_BITS-1:0] s2_thread,
	input  logic [VECTOR_LANES-1:0] s2_mask,
	input  logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s2_significand_le,
	input  logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s2_significand_se,
	input  logic [VECTOR_LANES-1:0] s2_guard,
	input  logic [VECTOR_LANES-1:0] s2_round,
	input  logic [VECTOR_LANES-1:0] s2_sticky,
	input  logic [VECTOR_LANES-1:0][EXP_BITS-1:0] s2_add_exponent,
	input  logic [VECTOR_LANES-1:0] s2_add_sign,
	input  logic [VECTOR_LANES-1:0] s2_logical_subtract,
	input  logic [VECTOR_LANES-1:0][2*SIG_BITS-1:0] s2_significand_product,
	input  logic [VECTOR_LANES-1:0][WIDE_EXP_BITS-1:0] s2_mul_exponent,
	input  logic [VECTOR_LANES-1:0] s2_mul_sign,
	input  logic [VECTOR_LANES-1:0] s2_result_is_inf,
	input  logic [VECTOR_LANES-1:0] s2_result_is_nan,
	output logic s3_valid,
	output fp_op_t s3_op,
	output logic [THREAD_BITS-1:0] s3_thread,
	output logic [VECTOR_LANES-1:0] s3_mask,
	output logic [VECTOR_LANES-1:0] s3_sign,
	output logic [VECTOR_LANES-1:0][WIDE_EXP_BITS-1:0] s3_exponent,
	output logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s3_significand,
	output logic [VECTOR_LANES-1:0] s3_guard,
	output logic [VECTOR_LANES-1:0] s3_round_bit,
	output logic [VECTOR_LANES-1:0] s3_sticky,
	output logic [VECTOR_LANES-1:0] s3_result_is_inf,
	output logic [VECTOR_LANES-1:0] s3_result_is_nan
);
	// Returns EXT_SIG_BITS for an all-zero value
	function automatic logic [LZC_BITS-1:0] count_leading_zeros(
		input logic [EXT_SIG_BITS-1:0] value);
		logic [LZC_BITS-1:0] count;

		count = LZC_BITS'(EXT_SIG_BITS);
		for (int i = 0; i < EXT_SIG_BITS; i++)
		begin
			if (value[i])
				count = LZC_BITS'(EXT_SIG_BITS - 1 - i);
		end
		return count;
	endfunction

	for (genvar lane = 0; lane < VECTOR_LANES; lane++)
	begin : lane_logic
		logic [EXT_SIG_BITS:0] sum;
		logic [LZC_BITS-1:0] lead_zeros;
		logic [EXT_SIG_BITS-1:0] sum_norm;
		logic [SIG_BITS-1:0] add_sig, mul_sig;
		logic add_guard, add_round, add_sticky;
		logic mul_guard, mul_round, mul_sticky;
		logic [WIDE_EXP_BITS-1:0] add_exp, mul_exp;
		logic [2*SIG_BITS-1:0] product;

		// Larger operand first, so subtraction never goes negative
		assign sum = s2_logical_subtract[lane]
			? {1'b0, s2_significand_le[lane], 3'b000} - {1'b0, s2_significand_se[lane],
				s2_guard[lane], s2_round[lane], s2_sticky[lane]}
			: {1'b0, s2_significand_le[lane], 3'b000} + {1'b0, s2_significand_se[lane],
				s2_guard[lane], s2_round[lane], s2_sticky[lane]};
		assign lead_zeros = count_leading_zeros(sum[EXT_SIG_BITS-1:0]);
		assign sum_norm = sum[EXT_SIG_BITS-1:0] << lead_zeros;
		assign product = s2_significand_product[lane];

		always_comb
		begin
			if (sum[EXT_SIG_BITS])
			begin
				// Carry out, shift right and keep the lost bit in sticky
				add_sig = sum[EXT_SIG_BITS -: SIG_BITS];
				{add_guard, add_round} = sum[3:2];
				add_sticky = |sum[1:0];
				add_exp = {2'b00, s2_add_exponent[lane]} + 1'b1;
			end
			else
			begin
				add_sig = sum_norm[EXT_SIG_BITS-1 -: SIG_BITS];
				{add_guard, add_round, add_sticky} = sum_norm[2:0];
				add_exp = {2'b00, s2_add_exponent[lane]} - WIDE_EXP_BITS'(lead_zeros);
			end
			if (sum == '0)
				add_exp = '0;
		end

		always_comb
		begin
			// Product of two normals is in [1, 4)
			if (product[2*SIG_BITS-1])
			begin
				mul_sig = product[2*SIG_BITS-1 -: SIG_BITS];
				{mul_guard, mul_round} = product[SIG_BITS-1 -: 2];
				mul_sticky = |product[SIG_BITS-3:0];
				mul_exp = s2_mul_exponent[lane] + 1'b1;
			end
			else
			begin
				mul_sig = product[2*SIG_BITS-2 -: SIG_BITS];
				{mul_guard, mul_round} = product[SIG_BITS-2 -: 2];
				mul_sticky = |product[SIG_BITS-4:0];
				mul_exp = s2_mul_exponent[lane];
			end
			// Zero operand gives zero product
			if (product[2*SIG_BITS-1 -: 2] == 2'b00)
				mul_exp = '0;
		end

		always_ff @(posedge clk)
		begin
			if (s2_op == OP_FMUL)
			begin
				s3_sign[lane] <= s2_mul_sign[lane];
				s3_exponent[lane] <= mul_exp;
				s3_significand[lane] <= mul_sig;
				s3_guard[lane] <= mul_guard;
				s3_round_bit[lane] <= mul_round;
				s3_sticky[lane] <= mul_sticky;
			end
			else
			begin
				s3_sign[lane] <= s2_add_sign[lane];
				s3_exponent[lane] <= add_exp;
				s3_significand[lane] <= add_sig;
				s3_guard[lane] <= add_guard;
				s3_round_bit[lane] <= add_round;
				s3_sticky[lane] <= add_sticky;
			end
			s3_result_is_inf[lane] <= s2_result_is_inf[lane];
			s3_result_is_nan[lane] <= s2_result_is_nan[lane];
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s3_valid <= 1'b0;
			s3_op <= OP_FADD;
			s3_thread <= '0;
			s3_mask <= '0;
		end
		else
		begin
			s3_valid <= s2_valid;
			s3_op <= s2_op;
			s3_thread <= s2_thread;
			s3_mask <= s2_mask;
		end
	end
endmodule

//--- rtl/fp_align_multiply_stage.sv
/*
 * Stage 2. Aligns the smaller significand and forms the full significand product.
 * Squashes on a matching rollback, like stage 1.
 */
`timescale 1ns/1ps

module fp_align_multiply_stage import fp_pipe_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic rollback_en,
	input  logic [THREAD_BITS-1:0] rollback_thread,
	input  pipeline_sel_t rollback_pipeline,
	input  logic s1_valid,
	input  fp_op_t s1_op,
	input  logic [THREAD_BITS-1:0] s1_thread,
	input  logic [VECTOR_LANES-1:0] s1_mask,
	input  logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_significand_le,
	input  logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_significand_se,
	input  logic [VECTOR_LANES-1:0] s1_logical_subtract,
	input  logic [VECTOR_LANES-1:0][ALIGN_SHIFT_BITS-1:0] s1_align_shift,
	input  logic [VECTOR_LANES-1:0][EXP_BITS-1:0] s1_add_exponent,
	input  logic [VECTOR_LANES-1:0] s1_add_sign,
	input  logic [VECTOR_LANES-1:0][WIDE_EXP_BITS-1:0] s1_mul_exponent,
	input  logic [VECTOR_LANES-1:0] s1_mul_sign,
	input  logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_multiplicand,
	input  logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_multiplier,
	input  logic [VECTOR_LANES-1:0] s1_result_is_inf,
	input  logic [VECTOR_LANES-1:0] s1_result_is_nan,
	output logic s2_valid,
	output fp_op_t s2_op,
	output logic [THREAD_BITS-1:0] s2_thread,
	output logic [VECTOR_LANES-1:0] s2_mask,
	output logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s2_significand_le,
	output logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s2_significand_se,
	output logic [VECTOR_LANES-1:0] s2_guard,
	output logic [VECTOR_LANES-1:0] s2_round,
	output logic [VECTOR_LANES-1:0] s2_sticky,
	output logic [VECTOR_LANES-1:0][EXP_BITS-1:0] s2_add_exponent,
	output logic [VECTOR_LANES-1:0] s2_add_sign,
	output logic [VECTOR_LANES-1:0] s2_logical_subtract,
	output logic [VECTOR_LANES-1:0][2*SIG_BITS-1:0] s2_significand_product,
	output logic [VECTOR_LANES-1:0][WIDE_EXP_BITS-1:0] s2_mul_exponent,
	output logic [VECTOR_LANES-1:0] s2_mul_sign,
	output logic [VECTOR_LANES-1:0] s2_result_is_inf,
	output logic [VECTOR_LANES-1:0] s2_result_is_nan
);
	logic squash;

	assign squash = rollback_en && rollback_pipeline == PIPE_MEM
		&& rollback_thread == s1_thread;

	for (genvar lane = 0; lane < VECTOR_LANES; lane++)
	begin : lane_logic
		logic [SIG_BITS-1:0] aligned;
		logic guard, round;
		logic [MAX_ALIGN_SHIFT-3:0] sticky_bits;

		// Bits shifted out land in guard, round, then the sticky window
		assign {aligned, guard, round, sticky_bits} =
			{s1_significand_se[lane], {MAX_ALIGN_SHIFT{1'b0}}} >> s1_align_shift[lane];

		always_ff @(posedge clk)
		begin
			s2_significand_le[lane] <= s1_significand_le[lane];
			s2_significand_se[lane] <= aligned;
			s2_guard[lane] <= guard;
			s2_round[lane] <= round;
			s2_sticky[lane] <= |sticky_bits;
			s2_add_exponent[lane] <= s1_add_exponent[lane];
			s2_add_sign[lane] <= s1_add_sign[lane];
			s2_logical_subtract[lane] <= s1_logical_subtract[lane];
			// Single-cycle 24 x 24 multiply
			s2_significand_product[lane] <= s1_multiplicand[lane] * s1_multiplier[lane];
			s2_mul_exponent[lane] <= s1_mul_exponent[lane];
			s2_mul_sign[lane] <= s1_mul_sign[lane];
			s2_result_is_inf[lane] <= s1_result_is_inf[lane];
			s2_result_is_nan[lane] <= s1_result_is_nan[lane];
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s2_valid <= 1'b0;
			s2_op <= OP_FADD;
			s2_thread <= '0;
			s2_mask <= '0;
		end
		else
		begin
			s2_valid <= s1_valid && !squash;
			s2_op <= s1_op;
			s2_thread <= s1_thread;
			s2_mask <= s1_mask;
		end
	end
endmodule

//--- rtl/fp_pipe_pkg.sv
/*
 * Shared widths and types for the four-stage vector FP pipeline.
 * IEEE single only. Denormals are flushed to zero and every NaN result is
 * emitted as one canonical quiet NaN.
 */
package fp_pipe_pkg;
	// Vector shape and thread index
	localparam int VECTOR_LANES = 4;
	localparam int THREAD_BITS = 2;

	// IEEE single field layout
	localparam int FLOAT_BITS = 32;
	localparam int EXP_BITS = 8;
	localparam int FRAC_BITS = 23;
	localparam int EXP_BIAS = 127;
	localparam int SIG_BITS = 24;

	// Signed exponent with room for overflow and underflow
	localparam int WIDE_EXP_BITS = EXP_BITS + 2;

	// Significand with guard, round and sticky appended
	localparam int EXT_SIG_BITS = SIG_BITS + 3;
	localparam int LZC_BITS = $clog2(EXT_SIG_BITS + 1);

	// Shifts of MAX_ALIGN_SHIFT or more leave only sticky
	localparam int ALIGN_SHIFT_BITS = 6;
	localparam int MAX_ALIGN_SHIFT = EXT_SIG_BITS;

	// Quiet NaN, positive, fraction MSB set
	localparam logic [FLOAT_BITS-1:0] CANONICAL_NAN = 32'h7fc0_0000;

	typedef enum logic [1:0]
	{
		OP_FADD,
		OP_FSUB,
		OP_FMUL
	} fp_op_t;

	// Pipeline named by a writeback rollback
	typedef enum logic
	{
		PIPE_SCALAR,
		PIPE_MEM
	} pipeline_sel_t;
endpackage

//--- rtl/fp_round_pack_stage.sv
/*
 * Stage 4. Round to nearest even, then pack. Overflow gives a signed infinity,
 * underflow a signed zero. An exact zero from FADD or FSUB is always +0.
 */
`timescale 1ns/1ps

module fp_round_pack_stage import fp_pipe_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic s3_valid,
	input  fp_op_t s3_op,
	input  logic [THREAD_BITS-1:0] s3_thread,
	input  logic [VECTOR_LANES-1:0] s3_mask,
	input  logic [VECTOR_LANES-1:0] s3_sign,
	input  logic [VECTOR_LANES-1:0][WIDE_EXP_BITS-1:0] s3_exponent,
	input  logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s3_significand,
	input  logic [VECTOR_LANES-1:0] s3_guard,
	input  logic [VECTOR_LANES-1:0] s3_round_bit,
	input  logic [VECTOR_LANES-1:0] s3_sticky,
	input  logic [VECTOR_LANES-1:0] s3_result_is_inf,
	input  logic [VECTOR_LANES-1:0] s3_result_is_nan,
	output logic result_valid,
	output logic [THREAD_BITS-1:0] result_thread,
	output logic [VECTOR_LANES-1:0] result_mask,
	output logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] result_value
);
	for (genvar lane = 0; lane < VECTOR_LANES; lane++)
	begin : lane_logic
		logic round_up;
		logic [SIG_BITS:0] rounded;
		logic [SIG_BITS-1:0] significand;
		logic [WIDE_EXP_BITS-1:0] exponent;
		logic sign;

		// Guard decides, round/sticky/LSB break the tie
		assign round_up = s3_guard[lane]
			& (s3_round_bit[lane] | s3_sticky[lane] | s3_significand[lane][0]);
		assign rounded = {1'b0, s3_significand[lane]} + round_up;

		// Mantissa carry renormalizes and bumps the exponent
		assign significand = rounded[SIG_BITS] ? rounded[SIG_BITS:1]
			: rounded[SIG_BITS-1:0];
		assign exponent = s3_exponent[lane] + rounded[SIG_BITS];

		// No hidden bit means an exact zero
		assign sign = (s3_significand[lane][SIG_BITS-1] || s3_op == OP_FMUL)
			? s3_sign[lane] : 1'b0;

		always_ff @(posedge clk)
		begin
			if (s3_result_is_nan[lane])
				result_value[lane] <= CANONICAL_NAN;
			else if (s3_result_is_inf[lane] || $signed(exponent) >= (2 ** EXP_BITS) - 1)
				result_value[lane] <= {sign, {EXP_BITS{1'b1}}, {FRAC_BITS{1'b0}}};
			else if ($signed(exponent) <= 0)
				result_value[lane] <= {sign, {(EXP_BITS + FRAC_BITS){1'b0}}};
			else
				result_value[lane] <= {sign, exponent[EXP_BITS-1:0],
					significand[FRAC_BITS-1:0]};
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			result_thread <= '0;
			result_mask <= '0;
		end
		else
		begin
			result_valid <= s3_valid;
			result_thread <= s3_thread;
			result_mask <= s3_mask;
		end
	end
endmodule

//--- rtl/fp_unpack_compare_stage.sv
/*
 * Stage 1. Unpacks both operands, orders them by magnitude and flags special results.
 * Denormal inputs are treated as zero. Squashes the issuing instruction when a
 * rollback for its thread targets this pipeline.
 */
`timescale 1ns/1ps

module fp_unpack_compare_stage import fp_pipe_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic issue_valid,
	input  fp_op_t issue_op,
	input  logic [THREAD_BITS-1:0] issue_thread,
	input  logic [VECTOR_LANES-1:0] issue_mask,
	input  logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] issue_operand_a,
	input  logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] issue_operand_b,
	input  logic rollback_en,
	input  logic [THREAD_BITS-1:0] rollback_thread,
	input  pipeline_sel_t rollback_pipeline,
	output logic s1_valid,
	output fp_op_t s1_op,
	output logic [THREAD_BITS-1:0] s1_thread,
	output logic [VECTOR_LANES-1:0] s1_mask,
	output logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_significand_le,
	output logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_significand_se,
	output logic [VECTOR_LANES-1:0] s1_logical_subtract,
	output logic [VECTOR_LANES-1:0][ALIGN_SHIFT_BITS-1:0] s1_align_shift,
	output logic [VECTOR_LANES-1:0][EXP_BITS-1:0] s1_add_exponent,
	output logic [VECTOR_LANES-1:0] s1_add_sign,
	output logic [VECTOR_LANES-1:0][WIDE_EXP_BITS-1:0] s1_mul_exponent,
	output logic [VECTOR_LANES-1:0] s1_mul_sign,
	output logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_multiplicand,
	output logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_multiplier,
	output logic [VECTOR_LANES-1:0] s1_result_is_inf,
	output logic [VECTOR_LANES-1:0] s1_result_is_nan
);
	logic squash;

	// Rollback only counts when it names this pipeline
	assign squash = rollback_en && rollback_pipeline == PIPE_MEM
		&& rollback_thread == issue_thread;

	for (genvar lane = 0; lane < VECTOR_LANES; lane++)
	begin : lane_logic
		logic [EXP_BITS-1:0] exp_a, exp_b;
		logic [FRAC_BITS-1:0] frac_a, frac_b;
		logic sign_a, sign_b;
		logic zero_a, zero_b, inf_a, inf_b, nan_a, nan_b;
		logic [SIG_BITS-1:0] sig_a, sig_b;
		logic a_larger;
		logic [EXP_BITS-1:0] exp_diff;
		logic add_nan, mul_nan, result_nan;

		assign {sign_a, exp_a, frac_a} = issue_operand_a[lane];
		assign {exp_b, frac_b} = issue_operand_b[lane][FLOAT_BITS-2:0];

		// Subtraction is addition with b negated
		assign sign_b = issue_operand_b[lane][FLOAT_BITS-1] ^ (issue_op == OP_FSUB);

		// Zero exponent covers denormals, which flush to zero
		assign zero_a = exp_a == '0;
		assign zero_b = exp_b == '0;
		assign inf_a = exp_a == '1 && frac_a == '0;
		assign inf_b = exp_b == '1 && frac_b == '0;
		assign nan_a = exp_a == '1 && frac_a != '0;
		assign nan_b = exp_b == '1 && frac_b != '0;

		// Hidden bit restored on normal values only
		assign sig_a = zero_a ? '0 : {1'b1, frac_a};
		assign sig_b = zero_b ? '0 : {1'b1, frac_b};

		// Ties keep a first
		assign a_larger = {exp_a, sig_a} >= {exp_b, sig_b};
		assign exp_diff = a_larger ? exp_a - exp_b : exp_b - exp_a;

		// inf - inf and 0 * inf have no defined value
		assign add_nan = nan_a | nan_b | (inf_a & inf_b & (sign_a ^ sign_b));
		assign mul_nan = nan_a | nan_b | (inf_a & zero_b) | (zero_a & inf_b);
		assign result_nan = issue_op == OP_FMUL ? mul_nan : add_nan;

		always_ff @(posedge clk)
		begin
			s1_significand_le[lane] <= a_larger ? sig_a : sig_b;
			s1_significand_se[lane] <= a_larger ? sig_b : sig_a;
			s1_logical_subtract[lane] <= sign_a ^ sign_b;
			s1_add_exponent[lane] <= a_larger ? exp_a : exp_b;
			s1_add_sign[lane] <= a_larger ? sign_a : sign_b;
			// Anything past the sticky window shifts the same
			if (exp_diff > EXP_BITS'(MAX_ALIGN_SHIFT))
				s1_align_shift[lane] <= ALIGN_SHIFT_BITS'(MAX_ALIGN_SHIFT);
			else
				s1_align_shift[lane] <= exp_diff[ALIGN_SHIFT_BITS-1:0];

			// Biased product exponent, may go negative
			s1_mul_exponent[lane] <= {2'b00, exp_a} + {2'b00, exp_b}
				- WIDE_EXP_BITS'(EXP_BIAS);
			s1_mul_sign[lane] <= sign_a ^ issue_operand_b[lane][FLOAT_BITS-1];
			s1_multiplicand[lane] <= sig_a;
			s1_multiplier[lane] <= sig_b;

			s1_result_is_nan[lane] <= result_nan;
			s1_result_is_inf[lane] <= (inf_a | inf_b) & ~result_nan;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s1_valid <= 1'b0;
			s1_op <= OP_FADD;
			s1_thread <= '0;
			s1_mask <= '0;
		end
		else
		begin
			s1_valid <= issue_valid && !squash;
			s1_op <= issue_op;
			s1_thread <= issue_thread;
			s1_mask <= issue_mask;
		end
	end
endmodule

//--- rtl/fp_vector_pipeline.sv
/*
 * Four-stage vector FP pipeline for FADD, FSUB and FMUL. Latency is 4 cycles
 * with no back-pressure. Rollback squashes only in stages 1 and 2.
 */
`timescale 1ns/1ps

module fp_vector_pipeline import fp_pipe_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic issue_valid,
	input  fp_op_t issue_op,
	input  logic [THREAD_BITS-1:0] issue_thread,
	input  logic [VECTOR_LANES-1:0] issue_mask,
	input  logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] issue_operand_a,
	input  logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] issue_operand_b,
	input  logic rollback_en,
	input  logic [THREAD_BITS-1:0] rollback_thread,
	input  pipeline_sel_t rollback_pipeline,
	output logic result_valid,
	output logic [THREAD_BITS-1:0] result_thread,
	output logic [VECTOR_LANES-1:0] result_mask,
	output logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] result_value
);
	// Stage 1 to stage 2
	logic s1_valid;
	fp_op_t s1_op;
	logic [THREAD_BITS-1:0] s1_thread;
	logic [VECTOR_LANES-1:0] s1_mask, s1_logical_subtract, s1_add_sign, s1_mul_sign;
	logic [VECTOR_LANES-1:0] s1_result_is_inf, s1_result_is_nan;
	logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_significand_le, s1_significand_se;
	logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s1_multiplicand, s1_multiplier;
	logic [VECTOR_LANES-1:0][ALIGN_SHIFT_BITS-1:0] s1_align_shift;
	logic [VECTOR_LANES-1:0][EXP_BITS-1:0] s1_add_exponent;
	logic [VECTOR_LANES-1:0][WIDE_EXP_BITS-1:0] s1_mul_exponent;

	// Stage 2 to stage 3
	logic s2_valid;
	fp_op_t s2_op;
	logic [THREAD_BITS-1:0] s2_thread;
	logic [VECTOR_LANES-1:0] s2_mask, s2_guard, s2_round, s2_sticky;
	logic [VECTOR_LANES-1:0] s2_add_sign, s2_logical_subtract, s2_mul_sign;
	logic [VECTOR_LANES-1:0] s2_result_is_inf, s2_result_is_nan;
	logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s2_significand_le, s2_significand_se;
	logic [VECTOR_LANES-1:0][EXP_BITS-1:0] s2_add_exponent;
	logic [VECTOR_LANES-1:0][2*SIG_BITS-1:0] s2_significand_product;
	logic [VECTOR_LANES-1:0][WIDE_EXP_BITS-1:0] s2_mul_exponent;

	// Stage 3 to stage 4
	logic s3_valid;
	fp_op_t s3_op;
	logic [THREAD_BITS-1:0] s3_thread;
	logic [VECTOR_LANES-1:0] s3_mask, s3_sign, s3_guard, s3_round_bit, s3_sticky;
	logic [VECTOR_LANES-1:0] s3_result_is_inf, s3_result_is_nan;
	logic [VECTOR_LANES-1:0][WIDE_EXP_BITS-1:0] s3_exponent;
	logic [VECTOR_LANES-1:0][SIG_BITS-1:0] s3_significand;

	// Boundary names match stage ports one to one
	fp_unpack_compare_stage unpack_compare_i (.*);
	fp_align_multiply_stage align_multiply_i (.*);
	fp_add_normalize_stage add_normalize_i (.*);
	fp_round_pack_stage round_pack_i (.*);
endmodule

//--- verification/fp_pipeline_vectors.svh
/*
 * Columns: index, name, opcode, thread, mask, operand a, operand b, rollback kind,
 * rollback stage, expected. Lanes in each 128-bit word run 3 down to 0.
 */
`ifndef FP_PIPELINE_VECTORS_SVH
`define FP_PIPELINE_VECTORS_SVH

localparam int NUM_VECTORS = 13;

// Rollback kinds
localparam int RB_NONE = 0;
localparam int RB_SQUASH = 1;
localparam int RB_SCALAR = 2;
localparam int RB_OTHER_THREAD = 3;

task automatic fill_vector_table();
	set_row(0, "add_basic", OP_FADD, 0, 4'b1111,
		{32'hbf800000, 32'h3fc00000, 32'h40000000, 32'h3f800000},
		{32'h40400000, 32'h3e800000, 32'h3f000000, 32'h3f800000}, RB_NONE, 0,
		{32'h40000000, 32'h3fe00000, 32'h40200000, 32'h40000000});
	// Equal operands give +0, lane 2 cancels to -0.5
	set_row(1, "sub_cancel", OP_FSUB, 1, 4'b0101,
		{32'h40a00000, 32'h3f800000, 32'h40400000, 32'h3f800000},
		{32'h3f400000, 32'h3fc00000, 32'h3f800000, 32'h3f800000}, RB_NONE, 0,
		{32'h40880000, 32'hbf000000, 32'h40000000, 32'h00000000});
	// Shift past 27 leaves sticky, ties go to even
	set_row(2, "add_sticky_ties", OP_FADD, 2, 4'b1010,
		{32'h4b800001, 32'h4b800000, 32'h3f800000, 32'h3f800000},
		{32'h3f800000, 32'h3f800000, 32'hb0800000, 32'h30800000}, RB_NONE, 0,
		{32'h4b800002, 32'h4b800000, 32'h3f800000, 32'h3f800000});
	// Sticky breaks a tie, rounding carry, overflow, denormals flushed
	set_row(3, "round_carry_ovf", OP_FADD, 3, 4'b1111,
		{32'h00400000, 32'h7f7fffff, 32'h3fffffff, 32'h4b800000},
		{32'h00400000, 32'h7f7fffff, 32'h33800000, 32'h3f800001}, RB_NONE, 0,
		{32'h00000000, 32'h7f800000, 32'h40000000, 32'h4b800001});
	set_row(4, "mul_basic", OP_FMUL, 0, 4'b0011,
		{32'h3f800001, 32'hc0000000, 32'h3fc00000, 32'h40000000},
		{32'h3f800001, 32'h3f000000, 32'h3fc00000, 32'h40400000}, RB_NONE, 0,
		{32'h3f800002, 32'hbf800000, 32'h40100000, 32'h40c00000});
	// Overflow, underflow and a signed zero product
	set_row(5, "mul_edges", OP_FMUL, 1, 4'b1100,
		{32'hc0400000, 32'h00800000, 32'h7f000000, 32'h3fffffff},
		{32'h00000000, 32'h00800000, 32'h40000000, 32'h3fffffff}, RB_NONE, 0,
		{32'h80000000, 32'h00000000, 32'h7f800000, 32'h407ffffe});
	set_row(6, "add_specials", OP_FADD, 2, 4'b1111,
		{32'hff800000, 32'h7f800001, 32'h7f800000, 32'h7f800000},
		{32'h40a00000, 32'h3f800000, 32'hff800000, 32'h3f800000}, RB_NONE, 0,
		{32'hff800000, 32'h7fc00000, 32'h7fc00000, 32'h7f800000});
	set_row(7, "mul_specials", OP_FMUL, 3, 4'b0110,
		{32'hff800000, 32'hffc00000, 32'h7f800000, 32'h00000000},
		{32'hff800000, 32'h00000000, 32'hc0000000, 32'h7f800000}, RB_NONE, 0,
		{32'h7f800000, 32'h7fc00000, 32'hff800000, 32'h7fc00000});
	// inf - inf, exact zeros and a deep cancellation
	set_row(8, "sub_specials", OP_FSUB, 0, 4'b1001,
		{32'h3f800000, 32'hc0200000, 32'h40800000, 32'h7f800000},
		{32'h3f7fffff, 32'hc0200000, 32'h40800000, 32'h7f800000}, RB_NONE, 0,
		{32'h33800000, 32'h00000000, 32'h00000000, 32'h7fc00000});
	set_row(9, "squash_stage1", OP_FADD, 1, 4'b1010,
		{4{32'h3f800000}}, {4{32'h3f800000}}, RB_SQUASH, 1, {4{32'h40000000}});
	set_row(10, "squash_stage2", OP_FMUL, 2, 4'b0101,
		{4{32'h40000000}}, {4{32'h40000000}}, RB_SQUASH, 2, {4{32'h40800000}});
	// Rollbacks that must not hit
	set_row(11, "rollback_scalar", OP_FADD, 3, 4'b0110,
		{4{32'h3f800000}}, {4{32'h40000000}}, RB_SCALAR, 1, {4{32'h40400000}});
	set_row(12, "rollback_other_thread", OP_FMUL, 0, 4'b1001,
		{4{32'h40000000}}, {4{32'h40200000}}, RB_OTHER_THREAD, 2, {4{32'h40a00000}});
endtask

`endif

//--- verification/fp_pipeline_tb.sv
/*
 * Table-driven testbench for the vector FP pipeline. Expected values are hand
 * worked IEEE results. Rollback rows run with the pipeline drained.
 */
`timescale 1ns/1ps

module fp_pipeline_tb import fp_pipe_pkg::*; ();
	`include "fp_pipeline_vectors.svh"

	// Reset, worst case per row (gap, drain, rollback wait), and drain margin
	localparam int WATCHDOG_CYCLES = 10 + NUM_VECTORS * 12 + 30;

	logic clk, reset, issue_valid, rollback_en;
	fp_op_t issue_op;
	logic [THREAD_BITS-1:0] issue_thread, rollback_thread;
	logic [VECTOR_LANES-1:0] issue_mask;
	logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] issue_operand_a, issue_operand_b;
	pipeline_sel_t rollback_pipeline;
	logic result_valid;
	logic [THREAD_BITS-1:0] result_thread;
	logic [VECTOR_LANES-1:0] result_mask;
	logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] result_value;

	// Stimulus table
	string names [NUM_VECTORS];
	fp_op_t ops [NUM_VECTORS];
	logic [THREAD_BITS-1:0] threads [NUM_VECTORS];
	logic [VECTOR_LANES-1:0] masks [NUM_VECTORS];
	logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] operand_a [NUM_VECTORS];
	logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] operand_b [NUM_VECTORS];
	logic [VECTOR_LANES-1:0][FLOAT_BITS-1:0] expected [NUM_VECTORS];
	int rb_kind [NUM_VECTORS];
	int rb_stage [NUM_VECTORS];

	// Rows in flight, oldest first
	int pending_row[$];
	int pending_cycle[$];
	int cycle_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int unexpected_results = 0;
	integer seed = 32'hac1d_8b0e;

	fp_vector_pipeline dut_i (.*);

	task automatic set_row(input int idx, input string name, input fp_op_t op,
		input int thread, input logic [3:0] mask, input logic [127:0] a,
		input logic [127:0] b, input int kind, input int stage, input logic [127:0] result);
		names[idx] = name;
		ops[idx] = op;
		threads[idx] = THREAD_BITS'(thread);
		masks[idx] = mask;
		operand_a[idx] = a;
		operand_b[idx] = b;
		rb_kind[idx] = kind;
		rb_stage[idx] = stage;
		expected[idx] = result;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Idle slot, nothing issued and no rollback
	task automatic idle_cycle();
		@(posedge clk);
		#1;
		issue_valid = 1'b0;
		rollback_en = 1'b0;
	endtask

	task automatic check_result();
		int idx, issued;
		bit row_ok;

		row_ok = 1'b1;
		if (pending_row.size() == 0)
		begin
			$display("result_valid rose with no instruction in flight (thread %0d)",
				result_thread);
			unexpected_results++;
			fail_count++;
			return;
		end
		idx = pending_row.pop_front();
		issued = pending_cycle.pop_front();
		assert (cycle_count - issued == 4)
		else
		begin
			$display("%s arrived after %0d cycles instead of 4", names[idx],
				cycle_count - issued);
			row_ok = 1'b0;
		end
		assert (result_thread == threads[idx])
		else
		begin
			$display("[FAIL] %s thread expected %0d actual %0d", names[idx],
				threads[idx], result_thread);
			row_ok = 1'b0;
		end
		assert (result_mask == masks[idx])
		else
		begin
			$display("[FAIL] %s mask expected %b actual %b", names[idx],
				masks[idx], result_mask);
			row_ok = 1'b0;
		end
		// Masked-off lanes compute too
		for (int lane = 0; lane < VECTOR_LANES; lane++)
		begin
			assert (result_value[lane] == expected[idx][lane])
			else
			begin
				$display("[FAIL] %s lane %0d expected %h actual %h", names[idx], lane,
					expected[idx][lane], result_value[lane]);
				row_ok = 1'b0;
			end
		end
		if (row_ok)
		begin
			$display("[PASS] %s", names[idx]);
			pass_count++;
		end
		else
		begin
			$display("%s finished with errors", names[idx]);
			fail_count++;
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clk)
	begin
		if (!reset && result_valid)
			check_result();
	end

	initial
	begin : driver
		int gap, results_before;

		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = OP_FADD;
		issue_thread = '0;
		issue_mask = '0;
		issue_operand_a = '0;
		issue_operand_b = '0;
		rollback_en = 1'b0;
		rollback_thread = '0;
		rollback_pipeline = PIPE_SCALAR;
		fill_vector_table();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < NUM_VECTORS; i++)
		begin
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) idle_cycle();
			// Rollback rows see an empty pipeline
			if (rb_kind[i] != RB_NONE)
			begin
				while (pending_row.size() != 0)
					idle_cycle();
			end
			results_before = unexpected_results;
			@(posedge clk);
			#1;
			issue_valid = 1'b1;
			issue_op = ops[i];
			issue_thread = threads[i];
			issue_mask = masks[i];
			issue_operand_a = operand_a[i];
			issue_operand_b = operand_b[i];
			rollback_thread = rb_kind[i] == RB_OTHER_THREAD ? threads[i] + 1'b1 : threads[i];
			rollback_pipeline = rb_kind[i] == RB_SCALAR ? PIPE_SCALAR : PIPE_MEM;
			// Stage 1 rollback rides with the issue
			rollback_en = rb_kind[i] != RB_NONE && rb_stage[i] == 1;
			if (rb_kind[i] != RB_SQUASH)
			begin
				// Issue cycle is the edge the inputs were launched after
				pending_row.push_back(i);
				pending_cycle.push_back(cycle_count);
			end
			if (rb_kind[i] != RB_NONE)
			begin
				@(posedge clk);
				#1;
				issue_valid = 1'b0;
				rollback_en = rb_stage[i] == 2;
				repeat (5) idle_cycle();
			end
			if (rb_kind[i] == RB_SQUASH)
			begin
				assert (unexpected_results == results_before)
				else
					$display("%s was rolled back but still produced a result", names[i]);
				if (unexpected_results == results_before)
				begin
					$display("[PASS] %s", names[i]);
					pass_count++;
				end
			end
		end
		idle_cycle();
		while (pending_row.size() != 0)
			idle_cycle();
		repeat (2) @(posedge clk);

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Run hung, not finished after %0d cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end
endmodule
